/* logic/synth_pkg.sv */
package synth_pkg;

    //----------------------------------------
    // Widths
    //----------------------------------------

    localparam int phase_w  = 16;  // Phase accumulator
    localparam int index_w  = 8;   // 256 points per cycle
    localparam int sample_w = 15;  // One voice, signed
    localparam int sound_w  = 16;  // Two voices summed, no saturation
    localparam int note_w   = 4;
    localparam int octave_w = 3;
    localparam int n_voices = 2;
    localparam int n_notes  = 12;  // C .. B, the rest are silent

    // Phase steps for octave 0, C near 381 Hz at 390.6 kHz sample rate
    localparam logic [phase_w - 1:0] base_step [n_notes] = '{
        16'd64,  16'd68,  16'd72,  16'd76,   // C  C# D  D#
        16'd81,  16'd85,  16'd91,  16'd96,   // E  F  F# G
        16'd102, 16'd108, 16'd114, 16'd121   // G# A  A# B
    };

    // abcdefgh, one entry per note value
    localparam logic [7:0] seg_pattern [16] = '{
        8'b10011100, 8'b10011101,  // C  C#
        8'b01111010, 8'b01111011,  // D  D#
        8'b10011110, 8'b10001110,  // E  F
        8'b10001111, 8'b10111100,  // F# G
        8'b10111101, 8'b11101110,  // G# A
        8'b11101111, 8'b00111110,  // A# B
        8'b00000000, 8'b00000000,  // Silent codes blank
        8'b00000000, 8'b00000000
    };

    // Note codes past B mute the voice
    function automatic logic note_silent(input logic [note_w - 1:0] note);
        return note >= n_notes;
    endfunction

endpackage

/* logic/tone_voice.sv */
`timescale 1ns/1ps

module tone_voice
    import synth_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        sample_tick,
    input  logic        [note_w   - 1:0] note,
    input  logic        [octave_w - 1:0] octave,
    input  logic                        req_ready,
    input  logic                        rsp_valid,
    input  logic signed [sample_w - 1:0] rsp_data,
    output logic                        req_valid,
    output logic        [index_w  - 1:0] req_index,
    output logic signed [sample_w - 1:0] sample,
    output logic                        sample_valid
);

    typedef enum logic [1:0] {
        st_idle,   // Waiting for the next sample tick
        st_req,    // Asking the arbiter for the table
        st_wait    // Granted, table answers next cycle
    } state_t;

    state_t state;

    logic [phase_w - 1:0] phase;       // Committed phase
    logic [phase_w - 1:0] step;        // Step latched on the tick
    logic [phase_w - 1:0] tick_step;
    logic [phase_w - 1:0] next_phase;

    //----------------------------------------
    // Step and index
    //----------------------------------------

    // Silent voice holds its phase
    assign tick_step  = note_silent(note) ? '0 : base_step[note] << octave;
    assign next_phase = phase + step;  // Wraps mod 2^phase_w

    assign req_index = next_phase[phase_w - 1 -: index_w];  // Top bits pick the point
    assign req_valid = (state == st_req);

    //----------------------------------------
    // Fetch FSM
    //----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            phase        <= '0;
            step         <= '0;
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;  // One-cycle pulse
            case (state)
                st_idle: begin
                    if (sample_tick) begin
                        step <= tick_step;
                        if (note_silent(note)) begin
                            sample       <= '0;    // No fetch, just zero
                            sample_valid <= 1'b1;
                        end else begin
                            state <= st_req;
                        end
                    end
                end
                st_req: begin
                    if (req_ready) begin
                        phase <= next_phase;  // Commit on handshake
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (rsp_valid) begin
                        sample       <= rsp_data;
                        sample_valid <= 1'b1;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* logic/wave_table_arbiter.sv */
`timescale 1ns/1ps

module wave_table_arbiter
    import synth_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic        [n_voices - 1:0] req_valid,
    input  logic        [index_w  - 1:0] req_index_0,
    input  logic        [index_w  - 1:0] req_index_1,
    input  logic signed [sample_w - 1:0] rd_data,
    output logic        [n_voices - 1:0] req_ready,
    output logic                        rd_en,
    output logic        [index_w  - 1:0] rd_index,
    output logic        [n_voices - 1:0] rsp_valid,
    output logic signed [sample_w - 1:0] rsp_data
);

    logic                  last_grant;  // High when voice 1 won last
    logic [n_voices - 1:0] grant;
    logic [n_voices - 1:0] rsp_sel;     // Owner of the read in flight

    //----------------------------------------
    // Round-robin grant
    //----------------------------------------

    // On a tie the voice that did not win last time goes first
    assign grant[0] = req_valid[0] & (~req_valid[1] |  last_grant);
    assign grant[1] = req_valid[1] & (~req_valid[0] | ~last_grant);

    assign req_ready = grant;
    assign rd_en     = |grant;
    assign rd_index  = grant[1] ? req_index_1 : req_index_0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_grant <= 1'b1;  // Voice 0 first out of reset
            rsp_sel    <= '0;
        end else begin
            rsp_sel <= grant;    // Table answers one cycle later
            if (|grant)
                last_grant <= grant[1];
        end
    end

    //----------------------------------------
    // Response routing
    //----------------------------------------

    // Data is shared, only the owner sees valid
    assign rsp_valid = rsp_sel;
    assign rsp_data  = rd_data;

endmodule

/* logic/wave_table.sv */
`timescale 1ns/1ps

module wave_table
    import synth_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_en,
    input  logic        [index_w  - 1:0] rd_index,
    output logic signed [sample_w - 1:0] rd_data
);

    localparam int q_len = 1 << (index_w - 2);  // Points per quarter

    // sin(k * pi / 128) * 16383, k = 0 .. 64
    localparam logic [sample_w - 2:0] quarter [q_len + 1] = '{
            0,   402,   804,  1205,  1606,  2005,  2404,  2801,
         3196,  3590,  3981,  4370,  4756,  5139,  5519,  5896,
         6270,  6639,  7005,  7366,  7723,  8075,  8423,  8765,
         9102,  9434,  9759, 10079, 10393, 10701, 11002, 11297,
        11585, 11865, 12139, 12405, 12664, 12916, 13159, 13395,
        13622, 13841, 14052, 14255, 14449, 14634, 14810, 14978,
        15136, 15285, 15425, 15556, 15678, 15790, 15892, 15985,
        16068, 16142, 16206, 16260, 16304, 16339, 16363, 16378,
        16383
    };

    logic [index_w - 2:0]  addr;   // 0 .. 64
    logic [sample_w - 2:0] mag;
    logic                  neg;

    //----------------------------------------
    // Fold the index onto one quarter
    //----------------------------------------

    // Falling quarters read the table backwards
    assign addr = rd_index[index_w - 2] ?
                  (index_w - 1)'(q_len) - {1'b0, rd_index[index_w - 3:0]} :
                  {1'b0, rd_index[index_w - 3:0]};

    assign mag = quarter[addr];
    assign neg = rd_index[index_w - 1];  // Second half is negative

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_data <= '0;
        else if (rd_en)
            rd_data <= neg ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    end

endmodule

/* logic/voice_mixer.sv */
`timescale 1ns/1ps

module voice_mixer
    import synth_pkg::*;
#(
    parameter int sample_div = 64  // Clocks per sample
)
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic signed [sample_w - 1:0] sample_0,
    input  logic signed [sample_w - 1:0] sample_1,
    input  logic                        sample_valid_0,
    input  logic                        sample_valid_1,
    output logic                        sample_tick,
    output logic signed [sound_w  - 1:0] sound,
    output logic                        sound_valid
);

    localparam int cnt_w = $clog2(sample_div);

    logic [cnt_w - 1:0]           div_cnt;
    logic                         got_0, got_1;    // Arrived since last tick
    logic                         have_0, have_1;  // Arrived by now
    logic signed [sample_w - 1:0] held_0, held_1;
    logic signed [sample_w - 1:0] cur_0, cur_1;

    //----------------------------------------
    // Sample rate divider
    //----------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else if (div_cnt == cnt_w'(sample_div - 1)) begin
            div_cnt     <= '0;
            sample_tick <= 1'b1;
        end else begin
            div_cnt     <= div_cnt + 1'b1;
            sample_tick <= 1'b0;
        end
    end

    //----------------------------------------
    // Collect both voices, then sum
    //----------------------------------------

    assign have_0 = got_0 | sample_valid_0;
    assign have_1 = got_1 | sample_valid_1;
    assign cur_0  = sample_valid_0 ? sample_0 : held_0;  // Bypass a late arrival
    assign cur_1  = sample_valid_1 ? sample_1 : held_1;

    always_ff @(posedge clk) begin
        if (sample_valid_0)
            held_0 <= sample_0;
        if (sample_valid_1)
            held_1 <= sample_1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            got_0       <= 1'b0;
            got_1       <= 1'b0;
            sound       <= '0;
            sound_valid <= 1'b0;
        end else begin
            sound_valid <= 1'b0;
            if (have_0 && have_1) begin
                sound       <= cur_0 + cur_1;  // Sign extended, cannot overflow
                sound_valid <= 1'b1;
                got_0       <= 1'b0;
                got_1       <= 1'b0;
            end else begin
                got_0 <= have_0;
                got_1 <= have_1;
            end
        end
    end

endmodule

/* logic/note_display.sv */
`timescale 1ns/1ps

module note_display
    import synth_pkg::*;
#(
    parameter int scan_div = 16  // Clocks per digit
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic [note_w - 1:0] note_0,
    input  logic [note_w - 1:0] note_1,
    output logic [         7:0] abcdefgh,
    output logic [         1:0] digit       // One-hot, bit 0 is voice 0
);

    localparam int cnt_w = $clog2(scan_div);

    logic [cnt_w  - 1:0] scan_cnt;
    logic [         1:0] digit_next;
    logic [note_w - 1:0] shown;      // Note for the digit lit next cycle

    // Rotate the one-hot select at the end of each slot
    assign digit_next = (scan_cnt == cnt_w'(scan_div - 1)) ? {digit[0], digit[1]} : digit;

    // Pattern follows the digit that is about to be lit
    assign shown = digit_next[0] ? note_0 : note_1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            digit    <= 2'b01;  // Digit 0 first
            abcdefgh <= '0;     // Blank
        end else begin
            if (scan_cnt == cnt_w'(scan_div - 1))
                scan_cnt <= '0;
            else
                scan_cnt <= scan_cnt + 1'b1;
            digit    <= digit_next;
            abcdefgh <= seg_pattern[shown];  // Codes 12 .. 15 are blank
        end
    end

endmodule

/* logic/synth_top.sv */
`timescale 1ns/1ps

module synth_top
    import synth_pkg::*;
#(
    parameter int sample_div = 64,
    parameter int scan_div   = 16
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [note_w   - 1:0] note_0,
    input  logic [note_w   - 1:0] note_1,
    input  logic [octave_w - 1:0] octave_0,
    input  logic [octave_w - 1:0] octave_1,
    output logic [sound_w  - 1:0] sound,
    output logic                  sound_valid,
    output logic [           7:0] abcdefgh,
    output logic [           1:0] digit
);

    logic                        sample_tick;
    logic                        req_valid_0, req_valid_1;
    logic        [index_w  - 1:0] req_index_0, req_index_1;
    logic        [n_voices - 1:0] req_ready;
    logic        [n_voices - 1:0] rsp_valid;
    logic signed [sample_w - 1:0] rsp_data;
    logic signed [sample_w - 1:0] sample_0, sample_1;
    logic                        sample_valid_0, sample_valid_1;
    logic                        rd_en;
    logic        [index_w  - 1:0] rd_index;
    logic signed [sample_w - 1:0] rd_data;

    //----------------------------------------
    // Voices
    //----------------------------------------

    tone_voice voice_0 (
        .clk          (clk),
        .rst          (rst),
        .sample_tick  (sample_tick),
        .note         (note_0),
        .octave       (octave_0),
        .req_ready    (req_ready[0]),
        .rsp_valid    (rsp_valid[0]),
        .rsp_data     (rsp_data),
        .req_valid    (req_valid_0),
        .req_index    (req_index_0),
        .sample       (sample_0),
        .sample_valid (sample_valid_0)
    );

    tone_voice voice_1 (
        .clk          (clk),
        .rst          (rst),
        .sample_tick  (sample_tick),
        .note         (note_1),
        .octave       (octave_1),
        .req_ready    (req_ready[1]),
        .rsp_valid    (rsp_valid[1]),
        .rsp_data     (rsp_data),
        .req_valid    (req_valid_1),
        .req_index    (req_index_1),
        .sample       (sample_1),
        .sample_valid (sample_valid_1)
    );

    //----------------------------------------
    // Shared wave table
    //----------------------------------------

    wave_table_arbiter arbiter (
        .clk         (clk),
        .rst         (rst),
        .req_valid   ({req_valid_1, req_valid_0}),
        .req_index_0 (req_index_0),
        .req_index_1 (req_index_1),
        .rd_data     (rd_data),
        .req_ready   (req_ready),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data)
    );

    wave_table table_rom (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    //----------------------------------------
    // Output side
    //----------------------------------------

    voice_mixer #(
        .sample_div (sample_div)
    ) mixer (
        .clk            (clk),
        .rst            (rst),
        .sample_0       (sample_0),
        .sample_1       (sample_1),
        .sample_valid_0 (sample_valid_0),
        .sample_valid_1 (sample_valid_1),
        .sample_tick    (sample_tick),
        .sound          (sound),
        .sound_valid    (sound_valid)
    );

    note_display #(
        .scan_div (scan_div)
    ) display (
        .clk      (clk),
        .rst      (rst),
        .note_0   (note_0),
        .note_1   (note_1),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 40  // ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;  // Free running, 50% duty

endmodule

/* tb/synth_tb.sv */
`timescale 1ns/1ps

module synth_tb
    import synth_pkg::*;
();

    localparam int sample_div    = 16;
    localparam int scan_div      = 4;
    localparam int clk_ns        = 40;
    localparam int total_samples = 8 + 80 + 96 + 48 + 64 + 12;  // Sum over tests 1 .. 6

    logic                  clk;
    logic                  rst;
    logic [note_w   - 1:0] note_0, note_1;
    logic [octave_w - 1:0] octave_0, octave_1;
    logic [sound_w  - 1:0] sound;
    logic                  sound_valid;
    logic [           7:0] abcdefgh;
    logic [           1:0] digit;

    int          fails = 0;
    int          fails_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lcg_state = 32'h74b92c1a;

    // Reference model state
    logic [phase_w - 1:0] phase_0, phase_1;
    logic [phase_w - 1:0] step_0, step_1;     // Captured at the tick like the voices
    logic                 silent_0, silent_1;
    int                   mag [0:64];         // Learned quarter magnitudes
    bit                   mag_known [0:64];
    logic                 in_reset;           // rst as seen at the last rising edge
    logic [note_w - 1:0]  disp_note_0, disp_note_1;
    int                   since_tick, valid_count, since_d0, since_d1;
    bit                   period_seen;

    tb_clock #(.period(clk_ns)) clock_gen (.clk(clk));

    synth_top #(
        .sample_div (sample_div),
        .scan_div   (scan_div)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .note_0      (note_0),
        .note_1      (note_1),
        .octave_0    (octave_0),
        .octave_1    (octave_1),
        .sound       (sound),
        .sound_valid (sound_valid),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

    //----------------------------------------
    // Model helpers
    //----------------------------------------

    function automatic logic [phase_w - 1:0] note_step(input logic [note_w - 1:0] n,
                                                       input logic [octave_w - 1:0] o);
        if (n >= 12)
            return '0;  // Silent voice keeps its phase
        return base_step[n] << o;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Quarter address mirrored in the falling quarters
    function automatic int fold_index(input logic [7:0] idx);
        return idx[6] ? 64 - int'(idx[5:0]) : int'(idx[5:0]);
    endfunction

    function automatic int model_value(input logic [7:0] idx);
        int m;
        m = mag[fold_index(idx)];
        return idx[7] ? -m : m;  // Second half negated
    endfunction

    // Sign check, then store the newly seen table point
    task automatic learn_value(input logic [7:0] idx, input int val);
        int    a;
        string want;
        a = fold_index(idx);
        if (a == 0)
            want = "0";
        else if (idx[7])
            want = "a negative value";
        else
            want = "a positive value";
        assert (a == 0 ? val == 0 : (idx[7] ? val < 0 : val > 0)) else begin
            $display("mismatch at %0t: wave[%0d] got %0d expected %s",
                     $time, idx, val, want);
            fails++;
        end
        mag[a]       = (val < 0) ? -val : val;
        mag_known[a] = 1'b1;
    endtask

    //----------------------------------------
    // Capture on the rising edge
    //----------------------------------------

    always @(posedge clk) begin
        in_reset = rst;
        if (!rst && uut.sample_tick) begin  // Voices latch notes on this edge
            step_0   = note_step(note_0, octave_0);
            step_1   = note_step(note_1, octave_1);
            silent_0 = note_0 >= 12;
            silent_1 = note_1 >= 12;
        end
        disp_note_0 = note_0;  // Display registers from these
        disp_note_1 = note_1;
    end

    //----------------------------------------
    // Sound checks on the falling edge
    //----------------------------------------

    always @(negedge clk) begin : check_mix
        logic [7:0] i0, i1;
        int         v, known_sum, n_unknown;
        if (rst || in_reset) begin
            phase_0     = '0;
            phase_1     = '0;
            since_tick  = 0;
            valid_count = 0;
            period_seen = 1'b0;
        end else begin
            since_tick++;
            if (uut.sample_tick) begin
                assert (!period_seen || valid_count == 1) else begin
                    $display("Sample period ending at %0t gave %0d sound_valid pulses, not one",
                             $time, valid_count);
                    fails++;
                end
                period_seen = 1'b1;
                since_tick  = 0;
                valid_count = 0;
            end
            assert (!(period_seen && since_tick == 6 && valid_count == 0)) else begin
                $display("sound_valid did not arrive after sample tick at %0t", $time);
                fails++;
            end
            if (sound_valid) begin
                valid_count++;
                phase_0   = phase_0 + step_0;  // Wraps mod 2^16
                phase_1   = phase_1 + step_1;
                i0        = phase_0[phase_w - 1 -: index_w];
                i1        = phase_1[phase_w - 1 -: index_w];
                v         = $signed(sound);
                known_sum = 0;
                n_unknown = 0;
                if (!silent_0) begin
                    if (mag_known[fold_index(i0)])
                        known_sum += model_value(i0);
                    else
                        n_unknown++;
                end
                if (!silent_1) begin
                    if (mag_known[fold_index(i1)])
                        known_sum += model_value(i1);
                    else
                        n_unknown++;
                end
                if (n_unknown == 0) begin
                    assert (v == known_sum) else begin
                        $display("mismatch at %0t: sound got %0d expected %0d",
                                 $time, v, known_sum);
                        fails++;
                    end
                end else if (n_unknown == 1) begin
                    if (!silent_0 && !mag_known[fold_index(i0)])
                        learn_value(i0, v - known_sum);
                    else
                        learn_value(i1, v - known_sum);
                end else if (i0 == i1) begin  // Both voices on one point
                    assert (v % 2 == 0) else begin
                        $display("mismatch at %0t: sound got %0d expected an even sum", $time, v);
                        fails++;
                    end
                    learn_value(i0, v / 2);
                end
            end
        end
    end

    //----------------------------------------
    // Display checks
    //----------------------------------------

    always @(negedge clk) begin
        if (rst || in_reset) begin
            since_d0 = 0;
            since_d1 = 0;
        end else begin
            since_d0++;
            since_d1++;
            assert (digit == 2'b01 || digit == 2'b10) else begin
                $display("mismatch at %0t: digit got %b expected 01 or 10", $time, digit);
                fails++;
            end
            if (digit == 2'b01) begin
                since_d0 = 0;
                assert (abcdefgh == seg_pattern[disp_note_0]) else begin
                    $display("mismatch at %0t: abcdefgh got %b expected %b",
                             $time, abcdefgh, seg_pattern[disp_note_0]);
                    fails++;
                end
            end
            if (digit == 2'b10) begin
                since_d1 = 0;
                assert (abcdefgh == seg_pattern[disp_note_1]) else begin
                    $display("mismatch at %0t: abcdefgh got %b expected %b",
                             $time, abcdefgh, seg_pattern[disp_note_1]);
                    fails++;
                end
            end
            assert (since_d0 <= 2 * scan_div && since_d1 <= 2 * scan_div) else begin
                $display("A display digit stayed dark too long at %0t", $time);
                fails++;
            end
        end
    end

    //----------------------------------------
    // Stimulus tasks
    //----------------------------------------

    task automatic apply_reset();
        @(negedge clk);  // Let a pending sound_valid pass
        rst = 1'b1;
        repeat (2) @(negedge clk);
        assert (sound == '0 && !sound_valid && digit == 2'b01 && abcdefgh == '0) else begin
            $display("mismatch at %0t: sound %0d sound_valid %b digit %b abcdefgh %b",
                     $time, sound, sound_valid, digit, abcdefgh);
            $display("  expected sound 0 sound_valid 0 digit 01 abcdefgh 00000000");
            fails++;
        end
        rst = 1'b0;
    endtask

    task automatic set_voices(input logic [3:0] n0, input logic [2:0] o0,
                              input logic [3:0] n1, input logic [2:0] o1);
        note_0   = n0;
        octave_0 = o0;
        note_1   = n1;
        octave_1 = o1;
    endtask

    // Returns on the falling edge where sound_valid is seen
    task automatic run_samples(input int n);
        int waited;
        repeat (n) begin
            @(negedge clk);
            waited = 1;
            while (!sound_valid && waited < 2 * sample_div) begin
                @(negedge clk);
                waited++;
            end
            assert (sound_valid) else begin
                $display("sound_valid did not arrive within %0d cycles at %0t",
                         2 * sample_div, $time);
                fails++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (fails == fails_at_start) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, fails - fails_at_start);
        end
        fails_at_start = fails;
    endtask

    //----------------------------------------
    // Test sequence
    //----------------------------------------

    initial begin
        rst = 1'b1;
        set_voices(4'd15, 3'd0, 4'd15, 3'd0);
        for (int a = 0; a <= 64; a++)
            mag_known[a] = 1'b0;
        mag[0]        = 0;      // Zero crossing
        mag_known[0]  = 1'b1;
        mag[64]       = 16383;  // Peak
        mag_known[64] = 1'b1;
        apply_reset();

        run_samples(8);
        finish_test("reset and silence");

        set_voices(4'd9, 3'd3, 4'd15, 3'd0);  // A at octave 3
        run_samples(80);
        finish_test("single voice waveform");

        set_voices(4'd0, 3'd2, 4'd15, 3'd0);
        run_samples(24);
        set_voices(4'd4, 3'd5, 4'd15, 3'd0);
        run_samples(24);
        set_voices(4'd11, 3'd1, 4'd15, 3'd0);
        run_samples(24);
        set_voices(4'd7, 3'd6, 4'd15, 3'd0);
        run_samples(24);
        finish_test("phase step rule");

        apply_reset();                        // Both phases from zero
        set_voices(4'd9, 3'd3, 4'd9, 3'd3);
        run_samples(24);
        set_voices(4'd2, 3'd4, 4'd9, 3'd3);
        run_samples(24);
        finish_test("two voices under arbitration");

        repeat (16) begin
            lcg_state = lcg_next(lcg_state);
            set_voices(lcg_state[19:16], lcg_state[22:20], lcg_state[27:24], lcg_state[30:28]);
            run_samples(4);
        end
        finish_test("random notes");

        set_voices(4'd0, 3'd1, 4'd11, 3'd2);
        run_samples(2);
        set_voices(4'd12, 3'd1, 4'd5, 3'd2);
        run_samples(2);
        set_voices(4'd3, 3'd4, 4'd15, 3'd0);
        run_samples(2);
        set_voices(4'd9, 3'd0, 4'd13, 3'd0);
        run_samples(2);
        set_voices(4'd14, 3'd0, 4'd1, 3'd7);
        run_samples(2);
        set_voices(4'd6, 3'd3, 4'd6, 3'd3);
        run_samples(2);
        finish_test("display");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (fails == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Twice the nominal run length
    initial begin
        #(total_samples * sample_div * clk_ns * 2);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

/* flist.f */
logic/synth_pkg.sv
logic/tone_voice.sv
logic/wave_table_arbiter.sv
logic/wave_table.sv
logic/voice_mixer.sv
logic/note_display.sv
logic/synth_top.sv
tb/tb_clock.sv
tb/synth_tb.sv
